// ==== design/trig_pkg.sv ====
////////////////////////////////////////////////////////////
// Debug trigger package
// Widths, tdata1 field positions, trigger type codes,
// match modes and privilege codes for the trigger bank
////////////////////////////////////////////////////////////

`default_nettype none

package trig_pkg;

  // Vector types with a meaning of their own
  typedef logic [31:0] word_t;        // CSR word or byte address
  typedef logic [1:0]  priv_lvl_t;    // Privilege level
  typedef logic [3:0]  byte_en_t;     // LSU byte enables
  typedef logic [3:0]  ttype_t;       // tdata1 type field
  typedef logic [3:0]  match_mode_t;  // mcontrol6 match field

  ////////////////////////////////////////////////////////////
  // Trigger types and match modes
  ////////////////////////////////////////////////////////////

  localparam ttype_t TTYPE_MCONTROL6 = 4'd6;
  localparam ttype_t TTYPE_DISABLED  = 4'd15;

  localparam match_mode_t MATCH_EQ = 4'd0;  // Address equal
  localparam match_mode_t MATCH_GE = 4'd2;  // Unsigned greater or equal
  localparam match_mode_t MATCH_LT = 4'd3;  // Unsigned less than

  // Only the two levels the core implements
  localparam priv_lvl_t PRIV_LVL_M = 2'd3;
  localparam priv_lvl_t PRIV_LVL_U = 2'd0;

  ////////////////////////////////////////////////////////////
  // tdata1 bit positions
  ////////////////////////////////////////////////////////////

  localparam int TDATA1_TTYPE_HIGH = 31;
  localparam int TDATA1_TTYPE_LOW  = 28;
  localparam int TDATA1_DMODE      = 27;  // Debug mode access only

  localparam int MC6_ACTION_LOW = 12;  // Action spans 15:12
  localparam int MC6_MATCH_HIGH = 10;
  localparam int MC6_MATCH_LOW  = 7;
  localparam int MC6_M          = 6;   // Match in machine mode
  localparam int MC6_U          = 3;   // Match in user mode
  localparam int MC6_EXECUTE    = 2;
  localparam int MC6_STORE      = 1;
  localparam int MC6_LOAD       = 0;

  // Disabled trigger, writable from debug mode only
  localparam word_t TDATA1_RST_VAL = {TTYPE_DISABLED, 1'b1, 27'd0};

endpackage : trig_pkg

`default_nettype wire

// ==== design/trig_cfg_if.sv ====
////////////////////////////////////////////////////////////
// Trigger configuration interface
// Decoded per-trigger settings from the CSR bank
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface trig_cfg_if
  import trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
);

  // One entry per trigger, enables already qualified by type
  logic [NUM_TRIGGERS-1:0] exec_en;   // Instruction address match
  logic [NUM_TRIGGERS-1:0] load_en;   // Match on loads
  logic [NUM_TRIGGERS-1:0] store_en;  // Match on stores
  logic [NUM_TRIGGERS-1:0] m_en;      // Active in machine mode
  logic [NUM_TRIGGERS-1:0] u_en;      // Active in user mode
  match_mode_t             mode [NUM_TRIGGERS];
  word_t                   addr [NUM_TRIGGERS];  // tdata2 compare value

  // CSR bank side
  modport bank (
    output exec_en, load_en, store_en, m_en, u_en, mode, addr
  );

  // Match side
  modport match (
    input exec_en, load_en, store_en, m_en, u_en, mode, addr
  );

endinterface : trig_cfg_if

`default_nettype wire

// ==== design/trig_csr_bank.sv ====
////////////////////////////////////////////////////////////
// Trigger CSR bank
// tselect plus one tdata1/tdata2 pair per trigger, WARL
// write resolution, field decode and read multiplexing
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module trig_csr_bank
  import trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input  logic  clk,
  input  logic  arst_n_i,

  // CSR write side
  input  word_t csr_wdata_i,
  input  logic  tselect_we_i,
  input  logic  tdata1_we_i,
  input  logic  tdata2_we_i,

  // CSR read side
  output word_t tselect_rdata_o,
  output word_t tdata1_rdata_o,
  output word_t tdata2_rdata_o,

  // Decoded configuration for the match units
  trig_cfg_if.bank cfg_o
);

  word_t  tselect_q;
  word_t  tdata1_q [NUM_TRIGGERS];
  word_t  tdata2_q [NUM_TRIGGERS];
  word_t  tdata1_n;        // WARL resolved tdata1 write value
  ttype_t wr_ttype;        // Type field of the write data
  logic   tselect_legal;   // Written index exists

  // Match field is WARL, only EQ, GE and LT are implemented
  function automatic match_mode_t match_resolve(match_mode_t mode);
    if ((mode == MATCH_GE) || (mode == MATCH_LT)) begin
      return mode;
    end
    return MATCH_EQ;
  endfunction

  ////////////////////////////////////////////////////////////
  // Write data resolution
  ////////////////////////////////////////////////////////////

  assign wr_ttype      = csr_wdata_i[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW];
  assign tselect_legal = (csr_wdata_i < word_t'(NUM_TRIGGERS));

  always_comb begin
    tdata1_n = TDATA1_RST_VAL;  // Unsupported types end up disabled
    if (wr_ttype == TTYPE_MCONTROL6) begin
      tdata1_n = '0;
      tdata1_n[TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] = TTYPE_MCONTROL6;
      tdata1_n[TDATA1_DMODE]                      = 1'b1;
      tdata1_n[MC6_ACTION_LOW+:4]                 = 4'd1;  // Enter debug mode
      tdata1_n[MC6_MATCH_HIGH:MC6_MATCH_LOW] =
        match_resolve(csr_wdata_i[MC6_MATCH_HIGH:MC6_MATCH_LOW]);
      tdata1_n[MC6_M]       = csr_wdata_i[MC6_M];
      tdata1_n[MC6_U]       = csr_wdata_i[MC6_U];
      tdata1_n[MC6_EXECUTE] = csr_wdata_i[MC6_EXECUTE];
      tdata1_n[MC6_STORE]   = csr_wdata_i[MC6_STORE];
      tdata1_n[MC6_LOAD]    = csr_wdata_i[MC6_LOAD];
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tselect_q <= '0;
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        tdata1_q[i] <= TDATA1_RST_VAL;
        tdata2_q[i] <= '0;
      end
    end else begin
      if (tselect_we_i && tselect_legal) begin
        tselect_q <= csr_wdata_i;  // Out of range writes are dropped
      end
      // Only the selected pair takes tdata writes
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        if (tdata1_we_i && (tselect_q == word_t'(i))) begin
          tdata1_q[i] <= tdata1_n;
        end
        if (tdata2_we_i && (tselect_q == word_t'(i))) begin
          tdata2_q[i] <= csr_wdata_i;  // Any compare value is legal
        end
      end
    end
  end

  // Read mux on the selected trigger
  always_comb begin
    tdata1_rdata_o = tdata1_q[0];
    tdata2_rdata_o = tdata2_q[0];
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == word_t'(i)) begin
        tdata1_rdata_o = tdata1_q[i];
        tdata2_rdata_o = tdata2_q[i];
      end
    end
  end

  assign tselect_rdata_o = tselect_q;

  // Field decode, enables only live on an mcontrol6 trigger
  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      cfg_o.exec_en[i]  = (tdata1_q[i][TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_MCONTROL6)
                          && tdata1_q[i][MC6_EXECUTE];
      cfg_o.load_en[i]  = (tdata1_q[i][TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_MCONTROL6)
                          && tdata1_q[i][MC6_LOAD];
      cfg_o.store_en[i] = (tdata1_q[i][TDATA1_TTYPE_HIGH:TDATA1_TTYPE_LOW] == TTYPE_MCONTROL6)
                          && tdata1_q[i][MC6_STORE];
      cfg_o.m_en[i]     = tdata1_q[i][MC6_M];
      cfg_o.u_en[i]     = tdata1_q[i][MC6_U];
      cfg_o.mode[i]     = tdata1_q[i][MC6_MATCH_HIGH:MC6_MATCH_LOW];
      cfg_o.addr[i]     = tdata2_q[i];
    end
  end

endmodule : trig_csr_bank

`default_nettype wire

// ==== design/lsu_access_range.sv ====
////////////////////////////////////////////////////////////
// LSU access range
// Lowest and highest byte address touched by an access
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module lsu_access_range
  import trig_pkg::*;
(
  input  word_t    lsu_addr_ex_i,
  input  byte_en_t lsu_be_ex_i,
  output word_t    addr_low_o,   // First enabled byte
  output word_t    addr_high_o   // Last enabled byte
);

  logic [1:0] low_lsb;
  logic [1:0] high_lsb;

  // Priority scan over the byte enables
  always_comb begin
    low_lsb  = 2'd0;  // No byte enabled gives the aligned word
    high_lsb = 2'd0;
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_ex_i[b]) begin
        low_lsb = 2'(b);  // Lowest index wins, last write
      end
    end
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_ex_i[b]) begin
        high_lsb = 2'(b);  // Highest index wins
      end
    end
  end

  assign addr_low_o  = {lsu_addr_ex_i[31:2], low_lsb};
  assign addr_high_o = {lsu_addr_ex_i[31:2], high_lsb};

endmodule : lsu_access_range

`default_nettype wire

// ==== design/trig_match.sv ====
////////////////////////////////////////////////////////////
// Trigger match unit
// Instruction and load/store address compare for a single
// trigger, gated by privilege and debug mode
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module trig_match
  import trig_pkg::*;
(
  // Trigger configuration
  input  logic        exec_en_i,
  input  logic        load_en_i,
  input  logic        store_en_i,
  input  logic        m_en_i,
  input  logic        u_en_i,
  input  match_mode_t mode_i,
  input  word_t       tdata2_i,

  // IF stage
  input  word_t       pc_if_i,
  input  priv_lvl_t   priv_lvl_if_i,

  // EX stage LSU access
  input  logic        lsu_valid_ex_i,
  input  logic        lsu_we_ex_i,
  input  byte_en_t    lsu_be_ex_i,
  input  word_t       lsu_addr_ex_i,
  input  word_t       addr_low_i,
  input  word_t       addr_high_i,
  input  priv_lvl_t   priv_lvl_ex_i,

  input  logic        debug_mode_i,

  output logic        match_if_o,  // Instruction address hit
  output logic        match_ex_o   // Load/store address hit
);

  logic     if_addr_hit;
  logic     ex_addr_hit;
  logic     priv_en_if;
  logic     priv_en_ex;
  logic     ex_dir_en;     // Access direction enabled
  byte_en_t byte_hit;      // Enabled byte sits at tdata2[1:0]

  ////////////////////////////////////////////////////////////
  // Instruction address compare
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (mode_i)
      MATCH_EQ: if_addr_hit = (pc_if_i == tdata2_i);
      MATCH_GE: if_addr_hit = (pc_if_i >= tdata2_i);
      MATCH_LT: if_addr_hit = (pc_if_i <  tdata2_i);
      default:  if_addr_hit = 1'b0;
    endcase
  end

  assign priv_en_if = (m_en_i && (priv_lvl_if_i == PRIV_LVL_M)) ||
                      (u_en_i && (priv_lvl_if_i == PRIV_LVL_U));

  assign match_if_o = exec_en_i && priv_en_if && !debug_mode_i && if_addr_hit;

  ////////////////////////////////////////////////////////////
  // Load/store address compare
  ////////////////////////////////////////////////////////////

  // One bit per byte lane
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_hit[b] = lsu_be_ex_i[b] && (tdata2_i[1:0] == 2'(b));
    end
  end

  // GE needs only the top byte, LT only the bottom byte
  always_comb begin
    case (mode_i)
      MATCH_EQ: ex_addr_hit = (lsu_addr_ex_i[31:2] == tdata2_i[31:2]) && (|byte_hit);
      MATCH_GE: ex_addr_hit = (addr_high_i >= tdata2_i);
      MATCH_LT: ex_addr_hit = (addr_low_i  <  tdata2_i);
      default:  ex_addr_hit = 1'b0;
    endcase
  end

  assign priv_en_ex = (m_en_i && (priv_lvl_ex_i == PRIV_LVL_M)) ||
                      (u_en_i && (priv_lvl_ex_i == PRIV_LVL_U));
  assign ex_dir_en  = (load_en_i && !lsu_we_ex_i) || (store_en_i && lsu_we_ex_i);

  assign match_ex_o = lsu_valid_ex_i && ex_dir_en && priv_en_ex && !debug_mode_i &&
                      ex_addr_hit;

endmodule : trig_match

`default_nettype wire

// ==== design/debug_triggers.sv ====
////////////////////////////////////////////////////////////
// Debug trigger bank
// mcontrol6 triggers with IF stage instruction address
// and EX stage load/store address matching
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module debug_triggers
  import trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2  // 1 to 4
) (
  input  logic      clk,
  input  logic      arst_n_i,

  // CSR access
  input  word_t     csr_wdata_i,
  input  logic      tselect_we_i,
  input  logic      tdata1_we_i,
  input  logic      tdata2_we_i,
  output word_t     tselect_rdata_o,
  output word_t     tdata1_rdata_o,
  output word_t     tdata2_rdata_o,

  // IF stage
  input  word_t     pc_if_i,
  input  priv_lvl_t priv_lvl_if_i,

  // EX stage LSU
  input  logic      lsu_valid_ex_i,
  input  word_t     lsu_addr_ex_i,
  input  logic      lsu_we_ex_i,
  input  byte_en_t  lsu_be_ex_i,
  input  priv_lvl_t priv_lvl_ex_i,

  input  logic      debug_mode_i,  // Core halted in debug mode

  output logic      trigger_match_if_o,
  output logic      trigger_match_ex_o
);

  logic [NUM_TRIGGERS-1:0] match_if;  // Per trigger hits
  logic [NUM_TRIGGERS-1:0] match_ex;
  word_t                   addr_low;
  word_t                   addr_high;

  trig_cfg_if #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_cfg ();

  trig_csr_bank #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) u_csr_bank (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .csr_wdata_i     (csr_wdata_i),
    .tselect_we_i    (tselect_we_i),
    .tdata1_we_i     (tdata1_we_i),
    .tdata2_we_i     (tdata2_we_i),
    .tselect_rdata_o (tselect_rdata_o),
    .tdata1_rdata_o  (tdata1_rdata_o),
    .tdata2_rdata_o  (tdata2_rdata_o),
    .cfg_o           (u_cfg.bank)
  );

  // Shared by all match units
  lsu_access_range u_access_range (
    .lsu_addr_ex_i (lsu_addr_ex_i),
    .lsu_be_ex_i   (lsu_be_ex_i),
    .addr_low_o    (addr_low),
    .addr_high_o   (addr_high)
  );

  ////////////////////////////////////////////////////////////
  // One match unit per trigger
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : gen_match
    trig_match u_match (
      .exec_en_i      (u_cfg.exec_en[i]),
      .load_en_i      (u_cfg.load_en[i]),
      .store_en_i     (u_cfg.store_en[i]),
      .m_en_i         (u_cfg.m_en[i]),
      .u_en_i         (u_cfg.u_en[i]),
      .mode_i         (u_cfg.mode[i]),
      .tdata2_i       (u_cfg.addr[i]),
      .pc_if_i        (pc_if_i),
      .priv_lvl_if_i  (priv_lvl_if_i),
      .lsu_valid_ex_i (lsu_valid_ex_i),
      .lsu_we_ex_i    (lsu_we_ex_i),
      .lsu_be_ex_i    (lsu_be_ex_i),
      .lsu_addr_ex_i  (lsu_addr_ex_i),
      .addr_low_i     (addr_low),
      .addr_high_i    (addr_high),
      .priv_lvl_ex_i  (priv_lvl_ex_i),
      .debug_mode_i   (debug_mode_i),
      .match_if_o     (match_if[i]),
      .match_ex_o     (match_ex[i])
    );
  end

  assign trigger_match_if_o = |match_if;  // Any trigger hits
  assign trigger_match_ex_o = |match_ex;

endmodule : debug_triggers

`default_nettype wire

// ==== testbench/debug_triggers_chk.sv ====
////////////////////////////////////////////////////////////
// Debug trigger assertions
// Match gating and tselect range checks bound into the top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module debug_triggers_chk
  import trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input logic  clk,
  input logic  arst_n_i,
  input logic  debug_mode_i,
  input logic  lsu_valid_ex_i,
  input word_t tselect_rdata_i,
  input logic  match_if_i,
  input logic  match_ex_i
);

  int fail_count = 0;  // Failed assertions so far

  // Halted core never triggers
  a_debug_quiet : assert property (@(posedge clk) disable iff (!arst_n_i)
    debug_mode_i |-> !match_if_i && !match_ex_i)
    else begin
      fail_count++;
      $error("trigger match while in debug mode");
    end

  a_tselect_range : assert property (@(posedge clk) disable iff (!arst_n_i)
    tselect_rdata_i < word_t'(NUM_TRIGGERS))
    else begin
      fail_count++;
      $error("tselect holds a trigger index that does not exist");
    end

  a_ex_valid : assert property (@(posedge clk) disable iff (!arst_n_i)
    match_ex_i |-> lsu_valid_ex_i)
    else begin
      fail_count++;
      $error("load/store match without a valid access");
    end

  // All triggers come out of reset disabled
  a_reset_quiet : assert property (@(posedge clk)
    $rose(arst_n_i) |-> !match_if_i && !match_ex_i)
    else begin
      fail_count++;
      $error("trigger match right after reset release");
    end

endmodule : debug_triggers_chk

bind debug_triggers debug_triggers_chk #(.NUM_TRIGGERS(NUM_TRIGGERS)) u_chk (
  .clk             (clk),
  .arst_n_i        (arst_n_i),
  .debug_mode_i    (debug_mode_i),
  .lsu_valid_ex_i  (lsu_valid_ex_i),
  .tselect_rdata_i (tselect_rdata_o),
  .match_if_i      (trigger_match_if_o),
  .match_ex_i      (trigger_match_ex_o)
);

`default_nettype wire

// ==== testbench/tb_debug_triggers.sv ====
////////////////////////////////////////////////////////////
// Debug trigger bank testbench
// Random CSR and match stimulus against a reference model
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_debug_triggers
  import trig_pkg::*;
();

  localparam int CLK_PERIOD  = 20;
  localparam int NUM_TRIG    = 2;
  localparam int ROUNDS      = 12;  // Reconfigurations per match test
  localparam int PER_ROUND   = 16;  // Accesses per configuration
  localparam int PLAN_CYCLES = 60 + 2 * ROUNDS * (6 + PER_ROUND);
  localparam int WATCHDOG_NS = (PLAN_CYCLES + 100) * CLK_PERIOD;

  logic      clk, arst_n_i, tselect_we_i, tdata1_we_i, tdata2_we_i;
  logic      lsu_valid_ex_i, lsu_we_ex_i, debug_mode_i;
  logic      trigger_match_if_o, trigger_match_ex_o;
  word_t     csr_wdata_i, pc_if_i, lsu_addr_ex_i;
  word_t     tselect_rdata_o, tdata1_rdata_o, tdata2_rdata_o;
  priv_lvl_t priv_lvl_if_i, priv_lvl_ex_i;
  byte_en_t  lsu_be_ex_i;

  // Model of the CSRs that follows each rising edge
  int        m_tsel;
  word_t     m_td1 [NUM_TRIG];
  word_t     m_td2 [NUM_TRIG];
  word_t     tgt [NUM_TRIG];    // Last tdata2 per trigger to steer stimulus
  int        errors, checks;
  logic      chk_en;
  string     test_name;

  debug_triggers #(.NUM_TRIGGERS(NUM_TRIG)) u_debug_triggers (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // mcontrol6 keeps M, U, execute, store, load and modes 0/2/3
  function automatic word_t tdata1_warl(input word_t wd);
    match_mode_t m;
    m = wd[10:7];
    if (m != MATCH_GE && m != MATCH_LT) m = MATCH_EQ;
    if (wd[31:28] != TTYPE_MCONTROL6) return TDATA1_RST_VAL;
    return {4'd6, 1'b1, 11'd0, 4'd1, 1'b0, m, wd[6], 2'b00, wd[3:0]};
  endfunction

  function automatic logic priv_ok(input word_t td1, input priv_lvl_t p);
    return (p == PRIV_LVL_M && td1[6]) || (p == PRIV_LVL_U && td1[3]);
  endfunction

  function automatic logic if_hit(input word_t td1, input word_t td2, input word_t pc,
                                  input priv_lvl_t p, input logic dbg);
    logic cmp;
    case (td1[10:7])
      MATCH_EQ: cmp = (pc == td2);
      MATCH_GE: cmp = (pc >= td2);
      MATCH_LT: cmp = (pc < td2);
      default:  cmp = 1'b0;
    endcase
    return td1[31:28] == TTYPE_MCONTROL6 && td1[2] && priv_ok(td1, p) && !dbg && cmp;
  endfunction

  // Walks the enabled bytes for first, last and exact hit
  function automatic logic ex_hit(input word_t td1, input word_t td2, input logic valid,
                                  input logic we, input byte_en_t be, input word_t addr,
                                  input priv_lvl_t p, input logic dbg);
    word_t lo, hi, ba;
    logic  first, eq_any, cmp;
    lo = {addr[31:2], 2'b00};  // No byte enabled leaves the aligned word
    hi = lo;
    first = 1'b1;
    eq_any = 1'b0;
    for (int b = 0; b < 4; b++) begin
      ba = {addr[31:2], 2'b00} + word_t'(b);
      if (be[b]) begin
        if (first) lo = ba;
        first = 1'b0;
        hi = ba;
        if (ba == td2) eq_any = 1'b1;
      end
    end
    case (td1[10:7])
      MATCH_EQ: cmp = eq_any;
      MATCH_GE: cmp = (hi >= td2);
      MATCH_LT: cmp = (lo < td2);
      default:  cmp = 1'b0;
    endcase
    return valid && td1[31:28] == TTYPE_MCONTROL6 && (we ? td1[1] : td1[0]) &&
           priv_ok(td1, p) && !dbg && cmp;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input word_t exp, input word_t act);
    $display("ERR %s %s: expected %0h, actual %0h at %0t", test_name, what, exp, act, $time);
    errors++;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    tselect_we_i = 1'b0;  // Writes last one cycle
    tdata1_we_i  = 1'b0;
    tdata2_we_i  = 1'b0;
  endtask

  // 0 tselect, 1 tdata1, 2 tdata2
  task automatic write_csr(input int which, input word_t data);
    next_cycle();
    csr_wdata_i  = data;
    tselect_we_i = (which == 0);
    tdata1_we_i  = (which == 1);
    tdata2_we_i  = (which == 2);
  endtask

  task automatic config_trigger(input int t, input word_t td1, input word_t td2);
    write_csr(0, word_t'(t));
    write_csr(1, td1);
    write_csr(2, td2);
    tgt[t] = td2;
  endtask

  // Type 6 with random fields and a match mode from 0 to 3
  function automatic word_t rand_mc6(input logic exec, input logic ld, input logic st);
    word_t w;
    w = $urandom;
    w[31:28] = 4'd6;
    w[10:9]  = 2'b00;
    w[2:0]   = {exec, st, ld};
    return w;
  endfunction

  function automatic priv_lvl_t rand_priv();
    if ($urandom_range(0, 7) == 0) return 2'd1;  // Supervisor is never enabled
    return ($urandom_range(0, 1) == 0) ? PRIV_LVL_M : PRIV_LVL_U;
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison just ahead of each rising edge
  ////////////////////////////////////////////////////////////

  initial begin : compare_outputs
    logic exp_if;
    logic exp_ex;
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (chk_en) begin
        exp_if = 1'b0;
        exp_ex = 1'b0;
        for (int t = 0; t < NUM_TRIG; t++) begin
          exp_if |= if_hit(m_td1[t], m_td2[t], pc_if_i, priv_lvl_if_i, debug_mode_i);
          exp_ex |= ex_hit(m_td1[t], m_td2[t], lsu_valid_ex_i, lsu_we_ex_i, lsu_be_ex_i,
                           lsu_addr_ex_i, priv_lvl_ex_i, debug_mode_i);
        end
        if (tselect_rdata_o != word_t'(m_tsel))
          report_mismatch("tselect", word_t'(m_tsel), tselect_rdata_o);
        if (tdata1_rdata_o != m_td1[m_tsel])
          report_mismatch("tdata1", m_td1[m_tsel], tdata1_rdata_o);
        if (tdata2_rdata_o != m_td2[m_tsel])
          report_mismatch("tdata2", m_td2[m_tsel], tdata2_rdata_o);
        if (trigger_match_if_o != exp_if)
          report_mismatch("match_if", word_t'(exp_if), word_t'(trigger_match_if_o));
        if (trigger_match_ex_o != exp_ex)
          report_mismatch("match_ex", word_t'(exp_ex), word_t'(trigger_match_ex_o));
        checks += 5;
        // tdata writes go to the old selection
        if (tdata1_we_i) m_td1[m_tsel] = tdata1_warl(csr_wdata_i);
        if (tdata2_we_i) m_td2[m_tsel] = csr_wdata_i;
        if (tselect_we_i && csr_wdata_i < word_t'(NUM_TRIG)) m_tsel = int'(csr_wdata_i);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    word_t w;
    int    k;
    w = $urandom(32'h8d58_cd64);
    {arst_n_i, tselect_we_i, tdata1_we_i, tdata2_we_i, chk_en} = '0;
    {lsu_valid_ex_i, lsu_we_ex_i, debug_mode_i} = '0;
    {csr_wdata_i, pc_if_i, lsu_addr_ex_i, priv_lvl_if_i, priv_lvl_ex_i, lsu_be_ex_i} = '0;
    {errors, checks, m_tsel} = '0;
    for (int t = 0; t < NUM_TRIG; t++) begin
      m_td1[t] = TDATA1_RST_VAL;
      m_td2[t] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n_i  = 1'b1;
    chk_en    = 1'b1;  // First check sees the reset values
    test_name = "reset";
    next_cycle();
    test_name = "tselect_warl";
    write_csr(0, 32'd0);
    write_csr(0, 32'd1);
    write_csr(0, 32'd5);  // Out of range so 1 stays
    repeat (2) next_cycle();
    test_name = "tdata1_warl";
    for (int t = 0; t < NUM_TRIG; t++) begin
      write_csr(0, word_t'(t));
      w = $urandom;
      w[31:28] = 4'd6;
      w[10:7]  = 4'd1;  // Unimplemented mode
      write_csr(1, w);
      w = $urandom;
      w[31:28] = 4'(7 + $urandom_range(0, 14));  // Every type but 6
      write_csr(1, w);
      write_csr(2, $urandom);
      write_csr(1, rand_mc6(1'($urandom), 1'($urandom), 1'($urandom)));
    end
    write_csr(0, 32'd0);
    write_csr(0, 32'd1);
    write_csr(0, 32'd0);
    test_name = "if_match";
    repeat (ROUNDS) begin
      for (int t = 0; t < NUM_TRIG; t++) config_trigger(t, rand_mc6(1'b1, 1'b0, 1'b0), $urandom);
      repeat (PER_ROUND) begin
        next_cycle();
        k = $urandom_range(0, NUM_TRIG - 1);
        pc_if_i = ($urandom_range(0, 3) == 0) ? $urandom :
                  tgt[k] + word_t'($urandom_range(0, 2)) - 32'd1;  // Around the edge
        priv_lvl_if_i = rand_priv();
      end
    end
    test_name = "ex_match";
    repeat (ROUNDS) begin
      for (int t = 0; t < NUM_TRIG; t++)
        config_trigger(t, rand_mc6(1'b0, 1'($urandom), 1'($urandom)), $urandom);
      repeat (PER_ROUND) begin
        next_cycle();
        k = $urandom_range(0, NUM_TRIG - 1);
        lsu_addr_ex_i = ($urandom_range(0, 3) == 0) ? $urandom :
                        tgt[k] + word_t'($urandom_range(0, 8)) - 32'd4;
        lsu_be_ex_i    = byte_en_t'($urandom);
        lsu_we_ex_i    = 1'($urandom);
        lsu_valid_ex_i = ($urandom_range(0, 7) != 0);
        priv_lvl_ex_i  = rand_priv();
      end
    end
    // Equal hit on byte 2 of a halfword load spanning bytes 1 and 2
    config_trigger(0, 32'h6000_0041, 32'h0000_1002);
    next_cycle();
    {lsu_addr_ex_i, lsu_be_ex_i, lsu_we_ex_i} = {32'h0000_1000, 4'b0110, 1'b0};
    {lsu_valid_ex_i, priv_lvl_ex_i} = {1'b1, PRIV_LVL_M};
    next_cycle();
    lsu_valid_ex_i = 1'b0;
    test_name = "debug_mode";
    config_trigger(0, 32'h6000_0045, 32'h2000_0100);  // EQ, M mode, execute and load
    config_trigger(1, 32'h0, 32'h0);                  // Type 0 disables
    next_cycle();
    {pc_if_i, priv_lvl_if_i, lsu_addr_ex_i} = {32'h2000_0100, PRIV_LVL_M, 32'h2000_0100};
    {lsu_be_ex_i, lsu_valid_ex_i, lsu_we_ex_i} = {4'b0001, 1'b1, 1'b0};
    next_cycle();
    debug_mode_i = 1'b1;  // Same hitting inputs now masked
    repeat (3) next_cycle();
    debug_mode_i = 1'b0;
    repeat (2) next_cycle();
    errors += u_debug_triggers.u_chk.fail_count;  // Assertion failures count too
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule : tb_debug_triggers

`default_nettype wire

// ==== flist.f ====
design/trig_pkg.sv
design/trig_cfg_if.sv
design/trig_csr_bank.sv
design/lsu_access_range.sv
design/trig_match.sv
design/debug_triggers.sv
testbench/debug_triggers_chk.sv
testbench/tb_debug_triggers.sv

// ==== Makefile ====
SIM    := verilator
FLAGS  := --binary --timing --assert -sv
TOP    := tb_debug_triggers
FLIST  := flist.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
